/* include/av_defines.svh */
/*
 * Fixed constants for the audio/video test core.
 * Include wherever raster, SPI or I2S timing numbers are needed.
 */
`ifndef AV_DEFINES_SVH
`define AV_DEFINES_SVH

//////////////////////////////
// raster timing
//////////////////////////////

// clocks per line, whole raster
`define AV_H_TOTAL 400
// visible pixels per line
`define AV_H_ACTIVE 320
// clocks ahead of the visible pixels
`define AV_H_BPORCH 10
// lines per frame
`define AV_V_TOTAL 512
// visible lines per frame
`define AV_V_ACTIVE 240
// lines ahead of the visible lines
`define AV_V_BPORCH 10
// hsync column, a few clocks after vsync
`define AV_HS_X 3

//////////////////////////////
// spi receiver
//////////////////////////////

// flops per input synchronizer
`define AV_SYNC_STAGES 2

//////////////////////////////
// i2s serializer
//////////////////////////////

// mclk clocks per i2s bit
`define AV_SCLK_DIV 4
// bits per channel slot
`define AV_SLOT_BITS 32
// data bits at the head of a slot
`define AV_SAMPLE_BITS 16

`endif

/* rtl/av_pkg.sv */
/*
 * Shared width types for the audio/video test core.
 * Modules pull these in with a wildcard import in their header.
 */
package av_pkg;

    //////////////////////////////
    // video
    //////////////////////////////

    // x or y raster coordinate, covers up to 1023
    typedef logic [9:0] pixel_pos_t;

    // pixel, red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb_t;

    //////////////////////////////
    // link port
    //////////////////////////////

    // one byte off the spi link
    typedef logic [7:0] spi_byte_t;

    //////////////////////////////
    // audio
    //////////////////////////////

    // two's complement sample, one channel
    typedef logic signed [15:0] sample_t;

    // bit position within a 32-bit i2s slot
    typedef logic [4:0] slot_bit_t;

endpackage

/* rtl/raster_timing.sv */
/*
 * Horizontal and vertical raster counters for the 320x240 test mode.
 * Decodes frame start, line start and the active window as flags.
 */
`include "av_defines.svh"

module raster_timing
    import av_pkg::*;
(
    input  logic audgen_mclk,
    input  logic reset_n,
    output logic o_frame_start,
    output logic o_line_start,
    output logic o_active
);

    // current raster position
    pixel_pos_t x_q;
    pixel_pos_t y_q;

    logic x_wrap;
    logic y_wrap;
    logic h_window;
    logic v_window;

    // end of line and end of frame
    assign x_wrap = (x_q == pixel_pos_t'(`AV_H_TOTAL - 1));
    assign y_wrap = (y_q == pixel_pos_t'(`AV_V_TOTAL - 1));

    //////////////////////////////
    // counters
    //////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_q <= '0;
            y_q <= '0;
        end else begin
            // x runs every clock
            x_q <= x_wrap ? '0 : x_q + 1'b1;
            // y steps once per line
            if (x_wrap) begin
                y_q <= y_wrap ? '0 : y_q + 1'b1;
            end
        end
    end

    //////////////////////////////
    // flag decode
    //////////////////////////////

    // vsync point at the top left corner
    assign o_frame_start = (x_q == '0) && (y_q == '0);
    // hsync a few clocks into every line
    assign o_line_start = (x_q == pixel_pos_t'(`AV_HS_X));

    // visible window after the back porch
    assign h_window = (x_q >= `AV_H_BPORCH) && (x_q < `AV_H_BPORCH + `AV_H_ACTIVE);
    assign v_window = (y_q >= `AV_V_BPORCH) && (y_q < `AV_V_BPORCH + `AV_V_ACTIVE);
    assign o_active = h_window && v_window;

    // counters never leave the raster
    a_raster_bounds : assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        (x_q < `AV_H_TOTAL) && (y_q < `AV_V_TOTAL)
    );

endmodule

/* rtl/pixel_stage.sv */
/*
 * Registered video outputs driven from the raster flags.
 * Takes one received byte per visible pixel and shows it as gray.
 */
`include "av_defines.svh"

module pixel_stage
    import av_pkg::*;
(
    input  logic      audgen_mclk,
    input  logic      reset_n,
    input  logic      i_frame_start,
    input  logic      i_line_start,
    input  logic      i_active,
    input  logic      i_byte_valid,
    input  spi_byte_t i_byte,
    output logic      o_byte_ready,
    output rgb_t      o_video_rgb,
    output logic      o_video_de,
    output logic      o_video_vs,
    output logic      o_video_hs
);

    // byte moves on this clock
    logic take;

    // only visible pixels can consume a byte
    assign o_byte_ready = i_active;
    assign take = i_active && i_byte_valid;

    //////////////////////////////
    // video output registers
    //////////////////////////////

    // everything lands one clock after the raster position
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            o_video_vs  <= 1'b0;
            o_video_hs  <= 1'b0;
            o_video_de  <= 1'b0;
            o_video_rgb <= '0;
        end else begin
            o_video_vs <= i_frame_start;
            o_video_hs <= i_line_start;
            o_video_de <= i_active;
            // gray from the byte, black with nothing waiting
            if (take) begin
                o_video_rgb <= {3{i_byte}};
            end else begin
                o_video_rgb <= '0;
            end
        end
    end

    // blanking is always black
    a_black_in_blank : assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        !o_video_de |-> (o_video_rgb == '0)
    );

endmodule

/* rtl/spi_rx.sv */
/*
 * SPI mode-0 byte receiver on the link port, MSB first.
 * Inputs are synchronized into mclk, each full byte sits in a holding
 * register until the valid/ready handshake takes it.
 */
`include "av_defines.svh"

module spi_rx
    import av_pkg::*;
(
    input  logic      audgen_mclk,
    input  logic      reset_n,
    input  logic      i_spi_sck,
    input  logic      i_spi_mosi,
    input  logic      i_spi_cs_n,
    input  logic      i_byte_ready,
    output logic      o_byte_valid,
    output spi_byte_t o_byte,
    output logic      o_spi_overrun
);

    // {cs_n, mosi, sck} per synchronizer stage
    logic [2:0] sync_q [`AV_SYNC_STAGES];

    logic       sck_s;
    logic       mosi_s;
    logic       cs_n_s;
    logic       sck_prev_q;
    logic       sck_rise;
    logic [2:0] bit_cnt_q;
    spi_byte_t  shift_q;
    spi_byte_t  next_byte;
    logic       byte_done;
    logic       hold_free;

    //////////////////////////////
    // input synchronizers
    //////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            // cs_n idles high, sck idles low
            for (int i = 0; i < `AV_SYNC_STAGES; i++) begin
                sync_q[i] <= 3'b100;
            end
        end else begin
            sync_q[0] <= {i_spi_cs_n, i_spi_mosi, i_spi_sck};
            for (int i = 1; i < `AV_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign sck_s  = sync_q[`AV_SYNC_STAGES-1][0];
    assign mosi_s = sync_q[`AV_SYNC_STAGES-1][1];
    assign cs_n_s = sync_q[`AV_SYNC_STAGES-1][2];

    // mode 0, sample on rising sck
    assign sck_rise  = sck_s && !sck_prev_q;
    assign next_byte = {shift_q[6:0], mosi_s};
    assign byte_done = sck_rise && !cs_n_s && (bit_cnt_q == 3'd7);
    // holding register empty, or emptied this clock
    assign hold_free = !o_byte_valid || i_byte_ready;

    //////////////////////////////
    // bit counter and flags
    //////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            sck_prev_q    <= 1'b0;
            bit_cnt_q     <= '0;
            o_byte_valid  <= 1'b0;
            o_spi_overrun <= 1'b0;
        end else begin
            sck_prev_q <= sck_s;
            // deselect restarts the byte
            if (cs_n_s) begin
                bit_cnt_q <= '0;
            end else if (sck_rise) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
            if (byte_done && hold_free) begin
                o_byte_valid <= 1'b1;
            end else if (o_byte_valid && i_byte_ready) begin
                o_byte_valid <= 1'b0;
            end
            // sticky, new byte lost
            if (byte_done && !hold_free) begin
                o_spi_overrun <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // data path
    //////////////////////////////

    always_ff @(posedge audgen_mclk) begin
        if (sck_rise && !cs_n_s) begin
            shift_q <= next_byte;
        end
        if (byte_done && hold_free) begin
            o_byte <= next_byte;
        end
    end

    // handshake hold rule toward the pixel stage
    a_byte_held : assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        (o_byte_valid && !i_byte_ready) |=> (o_byte_valid && $stable(o_byte))
    );

endmodule

/* rtl/i2s_tx.sv */
/*
 * I2S serializer, sclk = mclk/4, 32-bit slots with 16 data bits then zeros.
 * Buffers one left/right pair, loaded at each left slot, else silence.
 */
`include "av_defines.svh"

module i2s_tx
    import av_pkg::*;
(
    input  logic    audgen_mclk,
    input  logic    reset_n,
    input  logic    i_sample_valid,
    input  sample_t i_sample_left,
    input  sample_t i_sample_right,
    output logic    o_sample_ready,
    output logic    o_audio_sclk,
    output logic    o_audio_lrck,
    output logic    o_audio_dac
);

    logic [1:0]                    div_q;
    slot_bit_t                     bit_q;
    slot_bit_t                     next_bit;
    logic [2*`AV_SAMPLE_BITS-1:0]  shift_q;
    logic [2*`AV_SAMPLE_BITS-1:0]  pair;
    logic                          buf_full_q;
    sample_t                       buf_left_q;
    sample_t                       buf_right_q;
    logic                          bit_edge;
    logic                          slot_end;
    logic                          left_start;
    logic                          data_bit;
    logic                          accept;

    //////////////////////////////
    // bit and slot timing
    //////////////////////////////

    // divider wrap is the falling sclk edge
    assign bit_edge   = (div_q == 2'(`AV_SCLK_DIV - 1));
    assign slot_end   = bit_edge && (bit_q == slot_bit_t'(`AV_SLOT_BITS - 1));
    // lrck high going low, left slot begins
    assign left_start = slot_end && o_audio_lrck;
    assign next_bit   = bit_q + 1'b1;
    // head of the slot carries data
    assign data_bit   = (next_bit < `AV_SAMPLE_BITS);

    // two-bit divider gives mclk/4
    assign o_audio_sclk = div_q[1];

    //////////////////////////////
    // sample buffer
    //////////////////////////////

    assign o_sample_ready = !buf_full_q;
    assign accept = i_sample_valid && !buf_full_q;
    // empty buffer sends a silent frame
    assign pair = buf_full_q ? {buf_left_q, buf_right_q} : '0;

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div_q        <= '0;
            bit_q        <= '0;
            o_audio_lrck <= 1'b0;
            o_audio_dac  <= 1'b0;
            shift_q      <= '0;
            buf_full_q   <= 1'b0;
        end else begin
            div_q <= div_q + 1'b1;
            if (bit_edge) begin
                bit_q <= next_bit;
                // msb goes out with the lrck change
                if (left_start) begin
                    o_audio_dac <= pair[2*`AV_SAMPLE_BITS-1];
                    shift_q     <= pair << 1;
                end else if (data_bit) begin
                    o_audio_dac <= shift_q[2*`AV_SAMPLE_BITS-1];
                    shift_q     <= shift_q << 1;
                end else begin
                    o_audio_dac <= 1'b0;
                end
            end
            if (slot_end) begin
                o_audio_lrck <= !o_audio_lrck;
            end
            // pair moves into the shifter
            if (left_start) begin
                buf_full_q <= 1'b0;
            end
            if (accept) begin
                buf_full_q <= 1'b1;
            end
        end
    end

    // pair payload only
    always_ff @(posedge audgen_mclk) begin
        if (accept) begin
            buf_left_q  <= i_sample_left;
            buf_right_q <= i_sample_right;
        end
    end

    // word select moves only at the end of a slot
    a_lrck_on_wrap : assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        !slot_end |=> $stable(o_audio_lrck)
    );

endmodule

/* rtl/av_core_top.sv */
/*
 * Top of the audio/video test core, all on the 12.288 MHz mclk.
 * Raster video with SPI bytes shown as gray pixels, plus I2S audio out.
 */
`include "av_defines.svh"

module av_core_top
    import av_pkg::*;
(
    input  logic    audgen_mclk,
    input  logic    reset_n,
    input  logic    i_spi_sck,
    input  logic    i_spi_mosi,
    input  logic    i_spi_cs_n,
    input  logic    i_sample_valid,
    input  sample_t i_sample_left,
    input  sample_t i_sample_right,
    output logic    o_sample_ready,
    output rgb_t    o_video_rgb,
    output logic    o_video_de,
    output logic    o_video_vs,
    output logic    o_video_hs,
    output logic    o_spi_overrun,
    output logic    o_audio_sclk,
    output logic    o_audio_lrck,
    output logic    o_audio_dac
);

    // raster flags
    logic      frame_start;
    logic      line_start;
    logic      active;
    // received byte handshake
    logic      byte_valid;
    logic      byte_ready;
    spi_byte_t rx_byte;

    //////////////////////////////
    // video path
    //////////////////////////////

    raster_timing u_raster (
        .audgen_mclk   (audgen_mclk),
        .reset_n       (reset_n),
        .o_frame_start (frame_start),
        .o_line_start  (line_start),
        .o_active      (active)
    );

    pixel_stage u_pixel (
        .audgen_mclk   (audgen_mclk),
        .reset_n       (reset_n),
        .i_frame_start (frame_start),
        .i_line_start  (line_start),
        .i_active      (active),
        .i_byte_valid  (byte_valid),
        .i_byte        (rx_byte),
        .o_byte_ready  (byte_ready),
        .o_video_rgb   (o_video_rgb),
        .o_video_de    (o_video_de),
        .o_video_vs    (o_video_vs),
        .o_video_hs    (o_video_hs)
    );

    //////////////////////////////
    // link port receiver
    //////////////////////////////

    spi_rx u_spi_rx (
        .audgen_mclk   (audgen_mclk),
        .reset_n       (reset_n),
        .i_spi_sck     (i_spi_sck),
        .i_spi_mosi    (i_spi_mosi),
        .i_spi_cs_n    (i_spi_cs_n),
        .i_byte_ready  (byte_ready),
        .o_byte_valid  (byte_valid),
        .o_byte        (rx_byte),
        .o_spi_overrun (o_spi_overrun)
    );

    //////////////////////////////
    // audio
    //////////////////////////////

    i2s_tx u_i2s_tx (
        .audgen_mclk    (audgen_mclk),
        .reset_n        (reset_n),
        .i_sample_valid (i_sample_valid),
        .i_sample_left  (i_sample_left),
        .i_sample_right (i_sample_right),
        .o_sample_ready (o_sample_ready),
        .o_audio_sclk   (o_audio_sclk),
        .o_audio_lrck   (o_audio_lrck),
        .o_audio_dac    (o_audio_dac)
    );

endmodule

/* tb/av_core_tb.sv */
/*
 * Directed testbench for the audio/video test core.
 * Covers reset state, raster timing, SPI byte to pixel, overrun and I2S audio.
 */
module av_core_tb
    import av_pkg::*;
;

    localparam int SEED_INIT   = 50;
    // mclk clocks per half sck period
    localparam int SPI_HALF    = 4;
    // three frames of video tests plus audio, with margin
    localparam int CYCLE_LIMIT = 800000;

    logic    clk;
    logic    reset_n;
    logic    spi_sck;
    logic    spi_mosi;
    logic    spi_cs_n;
    logic    sample_valid;
    sample_t sample_left;
    sample_t sample_right;
    logic    o_sample_ready;
    rgb_t    o_video_rgb;
    logic    o_video_de;
    logic    o_video_vs;
    logic    o_video_hs;
    logic    o_spi_overrun;
    logic    o_audio_sclk;
    logic    o_audio_lrck;
    logic    o_audio_dac;

    integer seed;
    int     cycle_cnt;
    int     check_cnt;
    int     err_cnt;
    // lrck edge tracking for the audio test
    logic   last_lrck;
    int     last_toggle;
    int     toggle_cnt;

    av_core_top uut (
        .audgen_mclk    (clk),
        .reset_n        (reset_n),
        .i_spi_sck      (spi_sck),
        .i_spi_mosi     (spi_mosi),
        .i_spi_cs_n     (spi_cs_n),
        .i_sample_valid (sample_valid),
        .i_sample_left  (sample_left),
        .i_sample_right (sample_right),
        .o_sample_ready (o_sample_ready),
        .o_video_rgb    (o_video_rgb),
        .o_video_de     (o_video_de),
        .o_video_vs     (o_video_vs),
        .o_video_hs     (o_video_hs),
        .o_spi_overrun  (o_spi_overrun),
        .o_audio_sclk   (o_audio_sclk),
        .o_audio_lrck   (o_audio_lrck),
        .o_audio_dac    (o_audio_dac)
    );

    //////////////////////////////
    // clock and run limit
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run passed %0d clock cycles without finishing", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("FAILED at time %0t: %s, got %0h, expected %0h",
                     $time, msg, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %s done, %0d errors", name, err_cnt - err_before);
    endtask

    // returns on a negedge with vs high
    task automatic wait_vs();
        while (o_video_vs !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    // mode 0, msb first, 8 mclk per sck period
    task automatic send_spi_byte(input spi_byte_t b);
        @(posedge clk);
        spi_cs_n <= 1'b0;
        spi_sck  <= 1'b0;
        repeat (SPI_HALF) @(posedge clk);
        for (int i = 7; i >= 0; i--) begin
            spi_mosi <= b[i];
            spi_sck  <= 1'b0;
            repeat (SPI_HALF) @(posedge clk);
            spi_sck <= 1'b1;
            repeat (SPI_HALF) @(posedge clk);
        end
        spi_sck <= 1'b0;
        repeat (SPI_HALF) @(posedge clk);
        spi_cs_n <= 1'b1;
        // room for the synchronizer to settle
        repeat (8) @(posedge clk);
    endtask

    // first de pixel shows the byte, rest of the frame black
    task automatic check_gray_frame(input spi_byte_t first, input spi_byte_t stray,
                                    input string tag);
        int lit;
        int stray_hits;
        lit = 0;
        stray_hits = 0;
        do @(negedge clk); while (!o_video_de);
        check_value(o_video_rgb, {3{first}}, {tag, " first de pixel"});
        do begin
            @(negedge clk);
            if (o_video_rgb != '0) begin
                lit++;
                if (o_video_rgb == {3{stray}}) begin
                    stray_hits++;
                end
            end
        end while (!o_video_vs);
        check_value(lit, 0, {tag, " non-black pixels after the first"});
        check_value(stray_hits, 0, {tag, " stray byte shown"});
    endtask

    // returns on the negedge where lrck has just fallen
    task automatic wait_left_slot();
        logic prev;
        do begin
            prev = o_audio_lrck;
            @(negedge clk);
        end while (!(prev && !o_audio_lrck));
        last_lrck   = 1'b0;
        last_toggle = cycle_cnt;
        toggle_cnt  = 0;
    endtask

    // dac on rising sclk, lrck edges timed along the way
    task automatic collect_audio_bits(input int n, output logic [127:0] bits);
        logic prev_sclk;
        int   got;
        prev_sclk = o_audio_sclk;
        got = 0;
        bits = '0;
        while (got < n) begin
            @(negedge clk);
            if (o_audio_lrck !== last_lrck) begin
                check_value(cycle_cnt - last_toggle, 128, "lrck half period");
                last_toggle = cycle_cnt;
                last_lrck   = o_audio_lrck;
                toggle_cnt++;
            end
            if (o_audio_sclk && !prev_sclk) begin
                check_value(o_audio_lrck, (got / 32) % 2, "lrck level for slot");
                bits = {bits[126:0], o_audio_dac};
                got++;
            end
            prev_sclk = o_audio_sclk;
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_reset_state();
        int err0;
        err0 = err_cnt;
        @(negedge clk);
        check_value(o_video_vs, 0, "vs after reset");
        check_value(o_video_hs, 0, "hs after reset");
        check_value(o_video_de, 0, "de after reset");
        check_value(o_video_rgb, 0, "rgb after reset");
        check_value(o_spi_overrun, 0, "overrun after reset");
        check_value(o_sample_ready, 1, "sample ready after reset");
        check_value(o_audio_sclk, 0, "sclk after reset");
        check_value(o_audio_lrck, 0, "lrck after reset");
        check_value(o_audio_dac, 0, "dac after reset");
        report_test("reset state", err0);
    endtask

    task automatic test_raster();
        int   err0;
        int   clocks;
        int   hs_cnt;
        int   de_lines;
        int   run;
        int   since_hs;
        int   bad_start;
        int   bad_len;
        logic prev_de;
        err0 = err_cnt;
        clocks = 0;
        hs_cnt = 0;
        de_lines = 0;
        run = 0;
        since_hs = 0;
        bad_start = 0;
        bad_len = 0;
        prev_de = 1'b0;
        wait_vs();
        do begin
            @(negedge clk);
            clocks++;
            since_hs++;
            if (o_video_hs) begin
                hs_cnt++;
                since_hs = 0;
            end
            if (o_video_de && !prev_de) begin
                de_lines++;
                if (since_hs != 7) bad_start++;
            end
            if (o_video_de) begin
                run++;
            end else if (prev_de) begin
                if (run != 320) bad_len++;
                run = 0;
            end
            prev_de = o_video_de;
        end while (!o_video_vs);
        check_value(clocks, 204800, "clocks between vs pulses");
        check_value(hs_cnt, 512, "hs pulses per frame");
        check_value(de_lines, 240, "lines with de");
        check_value(bad_start, 0, "de lines not starting 7 clocks after hs");
        check_value(bad_len, 0, "de runs not 320 clocks long");
        report_test("raster", err0);
    endtask

    task automatic test_byte_to_pixel();
        int        err0;
        spi_byte_t b;
        err0 = err_cnt;
        b = spi_byte_t'($random(seed));
        if (b == '0) b = 8'h80;
        wait_vs();
        send_spi_byte(b);
        // the byte must show once only
        check_gray_frame(b, b, "byte to pixel");
        check_value(o_spi_overrun, 0, "overrun with a single byte");
        report_test("byte to pixel", err0);
    endtask

    task automatic test_overrun();
        int        err0;
        spi_byte_t b1;
        spi_byte_t b2;
        err0 = err_cnt;
        b1 = spi_byte_t'($random(seed));
        b2 = spi_byte_t'($random(seed));
        if (b1 == '0) b1 = 8'h81;
        if (b2 == b1 || b2 == '0) b2 = ~b1;
        wait_vs();
        send_spi_byte(b1);
        send_spi_byte(b2);
        @(negedge clk);
        check_value(o_spi_overrun, 1, "overrun after second byte");
        check_gray_frame(b1, b2, "overrun");
        report_test("overrun", err0);
    endtask

    task automatic test_audio();
        int           err0;
        sample_t      l_smp;
        sample_t      r_smp;
        logic [127:0] got_bits;
        logic [127:0] exp_bits;
        err0 = err_cnt;
        l_smp = sample_t'($random(seed));
        r_smp = sample_t'($random(seed));
        @(posedge clk);
        sample_valid <= 1'b1;
        sample_left  <= l_smp;
        sample_right <= r_smp;
        // hold until ready, transfer on the next edge
        do @(negedge clk); while (!o_sample_ready);
        @(posedge clk);
        sample_valid <= 1'b0;
        @(negedge clk);
        check_value(o_sample_ready, 0, "ready with pair buffered");
        wait_left_slot();
        collect_audio_bits(128, got_bits);
        // left slot, right slot, then a silent frame
        exp_bits = {l_smp, 16'h0000, r_smp, 16'h0000, 64'h0};
        check_value(got_bits[127:96], exp_bits[127:96], "left slot bits");
        check_value(got_bits[95:64], exp_bits[95:64], "right slot bits");
        check_value(got_bits[63:32], exp_bits[63:32], "silent left slot");
        check_value(got_bits[31:0], exp_bits[31:0], "silent right slot");
        check_value(toggle_cnt, 3, "lrck toggles seen");
        report_test("audio", err0);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        seed = SEED_INIT;
        cycle_cnt = 0;
        check_cnt = 0;
        err_cnt = 0;
        reset_n = 1'b0;
        spi_sck = 1'b0;
        spi_mosi = 1'b0;
        spi_cs_n = 1'b1;
        sample_valid = 1'b0;
        sample_left = '0;
        sample_right = '0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        test_reset_state();
        test_raster();
        test_byte_to_pixel();
        test_overrun();
        test_audio();
        $display("5 tests, %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
rtl/av_pkg.sv
rtl/raster_timing.sv
rtl/pixel_stage.sv
rtl/spi_rx.sv
rtl/i2s_tx.sv
rtl/av_core_top.sv
tb/av_core_tb.sv

/* Bender.yml */
package:
  name: av_core

export_include_dirs:
  - include

sources:
  - files:
      - rtl/av_pkg.sv
      - rtl/raster_timing.sv
      - rtl/pixel_stage.sv
      - rtl/spi_rx.sv
      - rtl/i2s_tx.sv
      - rtl/av_core_top.sv
  - target: test
    files:
      - tb/av_core_tb.sv
